// ==== segre_macros.svh ====
`ifndef SEGRE_MACROS_SVH
`define SEGRE_MACROS_SVH

// Datapath and instruction word width
`define SEGRE_WORD_W 16

// Register file geometry
`define SEGRE_REG_W 3
`define SEGRE_NUM_REGS 8

// First fetch address out of reset
`define SEGRE_RESET_PC 16'h0000

`endif

// ==== segre_pkg.sv ====
`include "segre_macros.svh"

package segre_pkg;

typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_ADDI = 4'd4,
    OP_LD   = 4'd5,
    OP_ST   = 4'd6,
    OP_BEQ  = 4'd7
} op_e;

// Register format, rd = rs1 op rs2
typedef struct packed {
    op_e                        opcode;
    logic [`SEGRE_REG_W-1:0]    rd;
    logic [`SEGRE_REG_W-1:0]    rs1;
    logic [`SEGRE_REG_W-1:0]    rs2;
    logic [`SEGRE_WORD_W-4-3*`SEGRE_REG_W-1:0] funct;
} instr_r_t;

// Immediate format, rd doubles as second source for ST and BEQ
typedef struct packed {
    op_e                        opcode;
    logic [`SEGRE_REG_W-1:0]    rd;
    logic [`SEGRE_REG_W-1:0]    rs1;
    logic signed [`SEGRE_WORD_W-4-2*`SEGRE_REG_W-1:0] imm;
} instr_i_t;

typedef union packed {
    instr_r_t r;
    instr_i_t i;
} instr_u;

typedef struct packed {
    logic                       valid;
    logic                       we;
    logic [`SEGRE_REG_W-1:0]    rd;
} dst_t;

typedef struct packed {
    logic                       valid;
    op_e                        op;
    logic [`SEGRE_REG_W-1:0]    rd;
    logic [`SEGRE_WORD_W-1:0]   a;
    logic [`SEGRE_WORD_W-1:0]   b;
    logic [`SEGRE_WORD_W-1:0]   imm;  // Already sign extended
    logic [`SEGRE_WORD_W-1:0]   pc;
} id_ex_t;

typedef struct packed {
    logic                       valid;
    op_e                        op;
    logic [`SEGRE_REG_W-1:0]    rd;
    logic                       we;
    logic [`SEGRE_WORD_W-1:0]   alu;
    logic [`SEGRE_WORD_W-1:0]   sdata;
} ex_mem_t;

typedef struct packed {
    logic                       valid;
    logic [`SEGRE_REG_W-1:0]    rd;
    logic [`SEGRE_WORD_W-1:0]   data;
} wb_t;

typedef struct packed {
    logic block;        // Stage output register may not take a new entry
    logic inject_nops;  // Stage output register loads a bubble
} stage_ctl_t;

endpackage : segre_pkg

// ==== segre_if_stage.sv ====
`timescale 1ns/100ps
`include "segre_macros.svh"

module segre_if_stage (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  segre_pkg::stage_ctl_t       ctl_i,
    input  logic                        tkbr_i,
    input  logic [`SEGRE_WORD_W-1:0]    target_i,
    input  logic [`SEGRE_WORD_W-1:0]    imem_rdata_i,
    input  logic                        imem_hit_i,
    output logic [`SEGRE_WORD_W-1:0]    imem_addr_o,
    output segre_pkg::instr_u           instr_o,
    output logic [`SEGRE_WORD_W-1:0]    pc_o,
    output logic                        valid_o
);

logic [`SEGRE_WORD_W-1:0] pc_q;
logic [`SEGRE_WORD_W-1:0] pc_id_q;
segre_pkg::instr_u        instr_q;
logic                     valid_q;

assign imem_addr_o = pc_q;

// Redirect wins over any stall
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        pc_q <= `SEGRE_RESET_PC;
    end else if (tkbr_i) begin
        pc_q <= target_i;
    end else if (!ctl_i.block && imem_hit_i) begin
        pc_q <= pc_q + `SEGRE_WORD_W'(1);
    end
end

//////////////////////////////////////////////////////////////////////
// IF/ID register

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        valid_q <= 1'b0;
    end else if (tkbr_i || ctl_i.inject_nops) begin
        valid_q <= 1'b0;  // Wrong path or bubble
    end else if (!ctl_i.block) begin
        valid_q <= imem_hit_i;  // Miss loads an empty slot
    end
end

always_ff @(posedge clk_i) begin
    if (!ctl_i.block && imem_hit_i) begin
        instr_q <= imem_rdata_i;
        pc_id_q <= pc_q;
    end
end

assign instr_o = instr_q;
assign pc_o    = pc_id_q;
assign valid_o = valid_q;

endmodule : segre_if_stage

// ==== segre_id_stage.sv ====
`timescale 1ns/100ps
`include "segre_macros.svh"

module segre_id_stage (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  segre_pkg::stage_ctl_t       ctl_i,
    input  segre_pkg::instr_u           instr_i,
    input  logic [`SEGRE_WORD_W-1:0]    pc_i,
    input  logic                        valid_i,
    input  segre_pkg::wb_t              wb_i,
    output logic [`SEGRE_REG_W-1:0]     src_a_o,
    output logic [`SEGRE_REG_W-1:0]     src_b_o,
    output logic                        rd_src_a_o,
    output logic                        rd_src_b_o,
    output logic                        valid_o,
    output segre_pkg::id_ex_t           id_ex_o
);

logic [`SEGRE_WORD_W-1:0] rf_q [`SEGRE_NUM_REGS];
segre_pkg::op_e           op;
logic                     is_r;
logic                     is_st_beq;
logic [`SEGRE_REG_W-1:0]  rd;
logic [`SEGRE_WORD_W-1:0] imm_ext;
segre_pkg::id_ex_t        id_ex_q;

//////////////////////////////////////////////////////////////////////
// Decode

// Opcode sits at the same place in both formats
assign op = instr_i.r.opcode;

assign is_r      = op inside {segre_pkg::OP_ADD, segre_pkg::OP_SUB, segre_pkg::OP_AND};
assign is_st_beq = op inside {segre_pkg::OP_ST, segre_pkg::OP_BEQ};

assign src_a_o = is_r ? instr_i.r.rs1 : instr_i.i.rs1;
assign src_b_o = is_r ? instr_i.r.rs2 : instr_i.i.rd;  // Store data or compare operand
assign rd      = is_r ? instr_i.r.rd  : instr_i.i.rd;
assign imm_ext = `SEGRE_WORD_W'(instr_i.i.imm);  // Signed cast extends the sign

assign rd_src_a_o = valid_i && (is_r || is_st_beq ||
                    op inside {segre_pkg::OP_ADDI, segre_pkg::OP_LD});
assign rd_src_b_o = valid_i && (is_r || is_st_beq);
assign valid_o    = valid_i;

// Register file, new value visible the cycle after the write
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        for (int i = 0; i < `SEGRE_NUM_REGS; i++) begin
            rf_q[i] <= '0;
        end
    end else if (wb_i.valid) begin
        rf_q[wb_i.rd] <= wb_i.data;
    end
end

//////////////////////////////////////////////////////////////////////
// ID/EX register

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        id_ex_q.valid <= 1'b0;
    end else if (ctl_i.inject_nops) begin
        id_ex_q.valid <= 1'b0;
    end else if (!ctl_i.block) begin
        id_ex_q.valid <= valid_i;
    end
    if (!ctl_i.block) begin
        id_ex_q.op  <= op;
        id_ex_q.rd  <= rd;
        id_ex_q.a   <= rf_q[src_a_o];
        id_ex_q.b   <= rf_q[src_b_o];
        id_ex_q.imm <= imm_ext;
        id_ex_q.pc  <= pc_i;
    end
end

assign id_ex_o = id_ex_q;

a_rf_index: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_i.valid |-> int'(wb_i.rd) < `SEGRE_NUM_REGS)
    else $error("write to register %0d out of range", wb_i.rd);

endmodule : segre_id_stage

// ==== segre_ex_stage.sv ====
`timescale 1ns/100ps
`include "segre_macros.svh"

module segre_ex_stage (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  segre_pkg::stage_ctl_t       ctl_i,
    input  segre_pkg::id_ex_t           id_ex_i,
    output logic                        tkbr_o,
    output logic [`SEGRE_WORD_W-1:0]    target_o,
    output segre_pkg::dst_t             dst_o,
    output segre_pkg::ex_mem_t          ex_mem_o
);

logic [`SEGRE_WORD_W-1:0] alu;
logic                     writes;
segre_pkg::ex_mem_t       ex_mem_q;

always_comb begin
    alu    = '0;
    writes = 1'b0;
    case (id_ex_i.op)
        segre_pkg::OP_ADD: begin
            alu    = id_ex_i.a + id_ex_i.b;
            writes = 1'b1;
        end
        segre_pkg::OP_SUB: begin
            alu    = id_ex_i.a - id_ex_i.b;
            writes = 1'b1;
        end
        segre_pkg::OP_AND: begin
            alu    = id_ex_i.a & id_ex_i.b;
            writes = 1'b1;
        end
        segre_pkg::OP_ADDI, segre_pkg::OP_LD: begin
            alu    = id_ex_i.a + id_ex_i.imm;  // Sum or load address
            writes = 1'b1;
        end
        segre_pkg::OP_ST: alu = id_ex_i.a + id_ex_i.imm;
        default: ;  // NOP, BEQ and unknown codes
    endcase
end

// Branch resolves here
assign tkbr_o   = id_ex_i.valid && id_ex_i.op == segre_pkg::OP_BEQ && id_ex_i.a == id_ex_i.b;
assign target_o = id_ex_i.pc + `SEGRE_WORD_W'(1) + id_ex_i.imm;

assign dst_o = '{valid: id_ex_i.valid, we: writes, rd: id_ex_i.rd};

//////////////////////////////////////////////////////////////////////
// EX/MEM register

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        ex_mem_q.valid <= 1'b0;
    end else if (ctl_i.inject_nops) begin
        ex_mem_q.valid <= 1'b0;
    end else if (!ctl_i.block) begin
        ex_mem_q.valid <= id_ex_i.valid;
    end
    if (!ctl_i.block) begin
        ex_mem_q.op    <= id_ex_i.op;
        ex_mem_q.rd    <= id_ex_i.rd;
        ex_mem_q.we    <= writes;
        ex_mem_q.alu   <= alu;
        ex_mem_q.sdata <= id_ex_i.b;
    end
end

assign ex_mem_o = ex_mem_q;

// A taken branch is a real BEQ and moves on once released
a_tkbr_beq: assert property (@(posedge clk_i) disable iff (reset_i)
    tkbr_o && !ctl_i.block && !ctl_i.inject_nops
    |=> ex_mem_o.valid && ex_mem_o.op == segre_pkg::OP_BEQ)
    else $error("tkbr without a valid BEQ");

endmodule : segre_ex_stage

// ==== segre_mem_stage.sv ====
`timescale 1ns/100ps
`include "segre_macros.svh"

module segre_mem_stage (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  segre_pkg::stage_ctl_t       ctl_i,
    input  segre_pkg::ex_mem_t          ex_mem_i,
    input  logic [`SEGRE_WORD_W-1:0]    dmem_rdata_i,
    input  logic                        dmem_hit_i,
    output logic [`SEGRE_WORD_W-1:0]    dmem_addr_o,
    output logic [`SEGRE_WORD_W-1:0]    dmem_wdata_o,
    output logic                        dmem_rd_o,
    output logic                        dmem_wr_o,
    output segre_pkg::dst_t             dst_o,
    output segre_pkg::wb_t              wb_o,
    output segre_pkg::dst_t             wb_dst_o
);

segre_pkg::wb_t wb_q;
logic           we_q;

assign dmem_rd_o    = ex_mem_i.valid && ex_mem_i.op == segre_pkg::OP_LD;
assign dmem_wr_o    = ex_mem_i.valid && ex_mem_i.op == segre_pkg::OP_ST;
assign dmem_addr_o  = ex_mem_i.alu;
assign dmem_wdata_o = ex_mem_i.sdata;

assign dst_o = '{valid: ex_mem_i.valid, we: ex_mem_i.we, rd: ex_mem_i.rd};

//////////////////////////////////////////////////////////////////////
// MEM/WB register

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        wb_q.valid <= 1'b0;
    end else if (ctl_i.inject_nops) begin
        wb_q.valid <= 1'b0;  // Access still pending
    end else if (!ctl_i.block) begin
        wb_q.valid <= ex_mem_i.valid;
    end
    if (!ctl_i.block) begin
        we_q      <= ex_mem_i.we;
        wb_q.rd   <= ex_mem_i.rd;
        wb_q.data <= dmem_rd_o ? dmem_rdata_i : ex_mem_i.alu;
    end
end

// Only register writes show up as write-back events
assign wb_o     = '{valid: wb_q.valid && we_q, rd: wb_q.rd, data: wb_q.data};
assign wb_dst_o = '{valid: wb_q.valid, we: we_q, rd: wb_q.rd};

a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(dmem_rd_o && dmem_wr_o))
    else $error("load and store issued together");

a_miss_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (dmem_rd_o || dmem_wr_o) && !dmem_hit_i
    |=> $stable(dmem_addr_o) && $stable({dmem_rd_o, dmem_wr_o}))
    else $error("data access changed while waiting on a miss");

endmodule : segre_mem_stage

// ==== segre_controller.sv ====
`timescale 1ns/100ps
`include "segre_macros.svh"

module segre_controller (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        finish_test_i,
    input  logic                        imem_hit_i,
    input  logic                        dmem_hit_i,
    input  logic                        dmem_rd_i,
    input  logic                        dmem_wr_i,
    input  logic                        store_buffer_draining_i,
    input  logic                        valid_id_i,
    input  logic [`SEGRE_REG_W-1:0]     src_a_i,
    input  logic [`SEGRE_REG_W-1:0]     src_b_i,
    input  logic                        rd_src_a_i,
    input  logic                        rd_src_b_i,
    input  segre_pkg::dst_t             dst_ex_i,
    input  segre_pkg::dst_t             dst_mem_i,
    input  segre_pkg::dst_t             dst_wb_i,
    input  logic                        tkbr_i,
    output segre_pkg::stage_ctl_t       ctl_if_o,
    output segre_pkg::stage_ctl_t       ctl_id_o,
    output segre_pkg::stage_ctl_t       ctl_ex_o,
    output segre_pkg::stage_ctl_t       ctl_mem_o,
    output logic                        finish_test_o,
    output logic                        sel_mem_req_o
);

logic       hazard;
logic       mem_stall;
logic       block_ex;
logic       block_id;
logic       block_if;
logic [2:0] fin_q;

// True when a decode source waits on this pending write
function automatic logic dep(segre_pkg::dst_t d);
    return d.valid && d.we && ((rd_src_a_i && src_a_i == d.rd) ||
                               (rd_src_b_i && src_b_i == d.rd));
endfunction

//////////////////////////////////////////////////////////////////////
// Stall and flush

// A taken branch squashes the waiting instruction anyway
assign hazard = valid_id_i && !tkbr_i &&
                (dep(dst_ex_i) || dep(dst_mem_i) || dep(dst_wb_i));

assign mem_stall = ((dmem_rd_i || dmem_wr_i) && !dmem_hit_i) || store_buffer_draining_i;

// Blocks travel back toward fetch
assign block_ex = mem_stall;
assign block_id = block_ex || hazard;
assign block_if = block_id || !imem_hit_i || fin_q[0];

assign ctl_mem_o = '{block: mem_stall, inject_nops: mem_stall};
assign ctl_ex_o  = '{block: block_ex, inject_nops: 1'b0};  // EX makes no bubble of its own
assign ctl_id_o  = '{block: block_id, inject_nops: (hazard || tkbr_i) && !block_ex};
assign ctl_if_o  = '{block: block_if,
                     inject_nops: (!imem_hit_i || fin_q[0]) && !block_id};

//////////////////////////////////////////////////////////////////////
// Finish delay and memory port select

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        fin_q <= '0;
    end else begin
        fin_q <= {fin_q[1:0], fin_q[0] | finish_test_i};  // Sticky until reset
    end
end

assign finish_test_o = fin_q[2];

// Instruction side wins, data side only when fetch is happy
assign sel_mem_req_o = (dmem_rd_i || dmem_wr_i) && !dmem_hit_i && imem_hit_i;

a_id_blocks_if: assert property (@(posedge clk_i) disable iff (reset_i)
    ctl_id_o.block |-> ctl_if_o.block)
    else $error("ID blocked while IF runs");

a_tkbr_no_release: assert property (@(posedge clk_i) disable iff (reset_i)
    tkbr_i && $past(ctl_id_o.block) |-> ctl_id_o.block || ctl_id_o.inject_nops)
    else $error("stalled decode released under a taken branch");

endmodule : segre_controller

// ==== segre_core.sv ====
`timescale 1ns/100ps
`include "segre_macros.svh"

module segre_core (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic [`SEGRE_WORD_W-1:0]    imem_rdata_i,
    input  logic                        imem_hit_i,
    input  logic [`SEGRE_WORD_W-1:0]    dmem_rdata_i,
    input  logic                        dmem_hit_i,
    input  logic                        store_buffer_draining_i,
    input  logic                        finish_test_i,
    output logic [`SEGRE_WORD_W-1:0]    imem_addr_o,
    output logic [`SEGRE_WORD_W-1:0]    dmem_addr_o,
    output logic [`SEGRE_WORD_W-1:0]    dmem_wdata_o,
    output logic                        dmem_rd_o,
    output logic                        dmem_wr_o,
    output segre_pkg::wb_t              wb_o,
    output logic                        finish_test_o,
    output logic                        sel_mem_req_o
);

segre_pkg::stage_ctl_t    ctl_if;
segre_pkg::stage_ctl_t    ctl_id;
segre_pkg::stage_ctl_t    ctl_ex;
segre_pkg::stage_ctl_t    ctl_mem;
logic                     tkbr;
logic [`SEGRE_WORD_W-1:0] target;
segre_pkg::instr_u        instr;
logic [`SEGRE_WORD_W-1:0] pc;
logic                     valid_if;
logic [`SEGRE_REG_W-1:0]  src_a;
logic [`SEGRE_REG_W-1:0]  src_b;
logic                     rd_src_a;
logic                     rd_src_b;
logic                     valid_id;
segre_pkg::id_ex_t        id_ex;
segre_pkg::ex_mem_t       ex_mem;
segre_pkg::dst_t          dst_ex;
segre_pkg::dst_t          dst_mem;
segre_pkg::dst_t          dst_wb;

//////////////////////////////////////////////////////////////////////
// Pipeline stages

segre_if_stage u_if (
    .clk_i, .reset_i, .ctl_i(ctl_if), .tkbr_i(tkbr), .target_i(target),
    .imem_rdata_i, .imem_hit_i, .imem_addr_o,
    .instr_o(instr), .pc_o(pc), .valid_o(valid_if)
);

segre_id_stage u_id (
    .clk_i, .reset_i, .ctl_i(ctl_id), .instr_i(instr), .pc_i(pc), .valid_i(valid_if),
    .wb_i(wb_o), .src_a_o(src_a), .src_b_o(src_b), .rd_src_a_o(rd_src_a),
    .rd_src_b_o(rd_src_b), .valid_o(valid_id), .id_ex_o(id_ex)
);

segre_ex_stage u_ex (
    .clk_i, .reset_i, .ctl_i(ctl_ex), .id_ex_i(id_ex),
    .tkbr_o(tkbr), .target_o(target), .dst_o(dst_ex), .ex_mem_o(ex_mem)
);

segre_mem_stage u_mem (
    .clk_i, .reset_i, .ctl_i(ctl_mem), .ex_mem_i(ex_mem), .dmem_rdata_i, .dmem_hit_i,
    .dmem_addr_o, .dmem_wdata_o, .dmem_rd_o, .dmem_wr_o,
    .dst_o(dst_mem), .wb_o, .wb_dst_o(dst_wb)
);

// Hazard controller
segre_controller u_ctrl (
    .clk_i, .reset_i, .finish_test_i, .imem_hit_i, .dmem_hit_i,
    .dmem_rd_i(dmem_rd_o), .dmem_wr_i(dmem_wr_o), .store_buffer_draining_i,
    .valid_id_i(valid_id), .src_a_i(src_a), .src_b_i(src_b),
    .rd_src_a_i(rd_src_a), .rd_src_b_i(rd_src_b),
    .dst_ex_i(dst_ex), .dst_mem_i(dst_mem), .dst_wb_i(dst_wb), .tkbr_i(tkbr),
    .ctl_if_o(ctl_if), .ctl_id_o(ctl_id), .ctl_ex_o(ctl_ex), .ctl_mem_o(ctl_mem),
    .finish_test_o, .sel_mem_req_o
);

endmodule : segre_core

// ==== tb_segre_core.sv ====
`timescale 1ns/100ps
`include "segre_macros.svh"

module tb_segre_core;

localparam int          num_rows  = 4;
localparam logic [15:0] halt_word = 16'h703F;  // BEQ r0, r0, -1 spins on itself

logic                     clk_i = 1'b0;
logic                     reset_i;
logic [`SEGRE_WORD_W-1:0] imem_rdata_i;
logic                     imem_hit_i;
logic [`SEGRE_WORD_W-1:0] dmem_rdata_i;
logic                     dmem_hit_i;
logic                     store_buffer_draining_i;
logic                     finish_test_i;
logic [`SEGRE_WORD_W-1:0] imem_addr_o;
logic [`SEGRE_WORD_W-1:0] dmem_addr_o;
logic [`SEGRE_WORD_W-1:0] dmem_wdata_o;
logic                     dmem_rd_o;
logic                     dmem_wr_o;
segre_pkg::wb_t           wb_o;
logic                     finish_test_o;
logic                     sel_mem_req_o;

logic [15:0]    imem [32];
logic [15:0]    dmem [64];
logic [15:0]    prog_tab [num_rows][16];
int             imiss_tab [num_rows];  // Percent of cycles with an imem miss
int             dmiss_tab [num_rows];
bit             drain_tab [num_rows];
segre_pkg::wb_t exp_q [$];
int             seed = 32'h1866;
int             errors;
int             checks;
int             got_cnt;
int             fin_cycles;
int             cur_imiss;
int             cur_dmiss;
bit             cur_drain;
int             imiss_run;
int             dmiss_run;
int             drain_run;
bit             reset_seen;
bit             timed_out;
bit             sel_exp;
bit             fin_exp;

segre_core dut0 (.*);

always #10 clk_i = ~clk_i;

// Memory arrays answer the current address
assign imem_rdata_i = imem[imem_addr_o[4:0]];
assign dmem_rdata_i = dmem[dmem_addr_o[5:0]];

function automatic logic [15:0] r_word(input int op, input int rd, input int rs1, input int rs2);
    return {op[3:0], rd[2:0], rs1[2:0], rs2[2:0], 3'b000};
endfunction

function automatic logic [15:0] i_word(input int op, input int rd, input int rs1, input int imm);
    return {op[3:0], rd[2:0], rs1[2:0], imm[5:0]};
endfunction

function automatic logic [15:0] fill_word(input int addr);
    return 16'hA500 ^ (addr[15:0] * 16'd37);
endfunction

function automatic bit miss_roll(input int rate);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % 100 < rate;
endfunction

//////////////////////////////////////////////////////////////////////
// Program table

task automatic fill_table();
    for (int r = 0; r < num_rows; r++) begin
        for (int i = 0; i < 16; i++) begin
            prog_tab[r][i] = 16'h0000;
        end
    end
    // Dependences at distance one, two and three
    prog_tab[0][0] = i_word(segre_pkg::OP_ADDI, 1, 0, 5);
    prog_tab[0][1] = i_word(segre_pkg::OP_ADDI, 2, 1, 3);
    prog_tab[0][2] = r_word(segre_pkg::OP_ADD, 3, 1, 2);
    prog_tab[0][3] = r_word(segre_pkg::OP_SUB, 4, 3, 1);
    prog_tab[0][4] = r_word(segre_pkg::OP_AND, 5, 4, 2);
    prog_tab[0][5] = r_word(segre_pkg::OP_ADD, 6, 3, 4);
    prog_tab[0][6] = i_word(segre_pkg::OP_ADDI, 7, 7, -2);
    prog_tab[0][7] = r_word(segre_pkg::OP_ADD, 1, 1, 1);
    prog_tab[0][8] = halt_word;
    // Taken branch skips two, then one not taken
    prog_tab[1][0] = i_word(segre_pkg::OP_ADDI, 1, 0, 4);
    prog_tab[1][1] = i_word(segre_pkg::OP_ADDI, 2, 0, 4);
    prog_tab[1][2] = i_word(segre_pkg::OP_BEQ, 2, 1, 2);
    prog_tab[1][3] = i_word(segre_pkg::OP_ADDI, 3, 0, 1);
    prog_tab[1][4] = i_word(segre_pkg::OP_ADDI, 4, 0, 2);
    prog_tab[1][5] = i_word(segre_pkg::OP_ADDI, 5, 0, 7);
    prog_tab[1][6] = i_word(segre_pkg::OP_BEQ, 1, 5, 1);
    prog_tab[1][7] = i_word(segre_pkg::OP_ADDI, 6, 5, 1);
    prog_tab[1][8] = r_word(segre_pkg::OP_ADD, 7, 6, 5);
    prog_tab[1][9] = halt_word;
    // Loads and stores
    prog_tab[2][0] = i_word(segre_pkg::OP_ADDI, 1, 0, 10);
    prog_tab[2][1] = i_word(segre_pkg::OP_LD, 2, 1, 0);
    prog_tab[2][2] = i_word(segre_pkg::OP_LD, 3, 1, 3);
    prog_tab[2][3] = r_word(segre_pkg::OP_ADD, 4, 2, 3);
    prog_tab[2][4] = i_word(segre_pkg::OP_ST, 4, 1, 5);
    prog_tab[2][5] = i_word(segre_pkg::OP_LD, 5, 0, 15);
    prog_tab[2][6] = r_word(segre_pkg::OP_SUB, 6, 5, 2);
    prog_tab[2][7] = i_word(segre_pkg::OP_ST, 6, 1, -2);
    prog_tab[2][8] = i_word(segre_pkg::OP_LD, 7, 1, -2);
    prog_tab[2][9] = halt_word;
    // Counted loop with a backward branch
    prog_tab[3][0] = i_word(segre_pkg::OP_ADDI, 1, 0, 3);
    prog_tab[3][1] = i_word(segre_pkg::OP_ADDI, 2, 2, 2);
    prog_tab[3][2] = i_word(segre_pkg::OP_ADDI, 1, 1, -1);
    prog_tab[3][3] = i_word(segre_pkg::OP_BEQ, 0, 1, 1);
    prog_tab[3][4] = i_word(segre_pkg::OP_BEQ, 0, 0, -4);
    prog_tab[3][5] = i_word(segre_pkg::OP_ST, 2, 0, 20);
    prog_tab[3][6] = i_word(segre_pkg::OP_LD, 3, 0, 20);
    prog_tab[3][7] = halt_word;
    imiss_tab = '{30, 20, 25, 50};
    dmiss_tab = '{0, 0, 40, 50};
    drain_tab = '{0, 0, 1, 1};
endtask

//////////////////////////////////////////////////////////////////////
// Reference model, program order execution

task automatic run_reference(input int row, output int steps);
    logic [15:0]    regs [8];
    logic [15:0]    mem [64];
    logic [15:0]    w;
    logic [15:0]    a;
    logic [15:0]    imm;
    logic [15:0]    pc;
    segre_pkg::wb_t ev;
    bit             halted;
    for (int i = 0; i < 8; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        mem[i] = fill_word(i);
    end
    exp_q.delete();
    pc     = '0;
    steps  = 0;
    halted = 1'b0;
    while (!halted && steps < 200) begin
        w   = (pc < 16) ? prog_tab[row][pc[3:0]] : 16'h0000;
        a   = regs[w[8:6]];
        imm = {{10{w[5]}}, w[5:0]};
        ev  = '{valid: 1'b1, rd: w[11:9], data: '0};
        pc  = pc + 16'd1;
        steps++;
        case (w[15:12])
            segre_pkg::OP_ADD:  ev.data = a + regs[w[5:3]];
            segre_pkg::OP_SUB:  ev.data = a - regs[w[5:3]];
            segre_pkg::OP_AND:  ev.data = a & regs[w[5:3]];
            segre_pkg::OP_ADDI: ev.data = a + imm;
            segre_pkg::OP_LD:   ev.data = mem[6'(a + imm)];
            segre_pkg::OP_ST:   mem[6'(a + imm)] = regs[w[11:9]];
            segre_pkg::OP_BEQ: begin
                if (a == regs[w[11:9]]) begin
                    halted = (imm == 16'hFFFF);  // Branch onto itself
                    pc     = pc + imm;
                end
            end
            default: ;
        endcase
        if (w[15:12] inside {4'd1, 4'd2, 4'd3, 4'd4, 4'd5}) begin
            regs[ev.rd] = ev.data;
            exp_q.push_back(ev);
        end
    end
endtask

//////////////////////////////////////////////////////////////////////
// Cache and store buffer models

always @(posedge clk_i) begin
    if (miss_roll(cur_imiss) && imiss_run < 3) begin
        imem_hit_i <= 1'b0;
        imiss_run++;
    end else begin
        imem_hit_i <= 1'b1;
        imiss_run = 0;
    end
    if (miss_roll(cur_dmiss) && dmiss_run < 3) begin
        dmem_hit_i <= 1'b0;
        dmiss_run++;
    end else begin
        dmem_hit_i <= 1'b1;
        dmiss_run = 0;
    end
    if (cur_drain && miss_roll(15) && drain_run < 2) begin
        store_buffer_draining_i <= 1'b1;
        drain_run++;
    end else begin
        store_buffer_draining_i <= 1'b0;
        drain_run = 0;
    end
    // Store retires only when MEM moves on
    if (dmem_wr_o && dmem_hit_i && !store_buffer_draining_i) begin
        dmem[dmem_addr_o[5:0]] <= dmem_wdata_o;
    end
end

//////////////////////////////////////////////////////////////////////
// Output checks, sampled mid cycle

always @(negedge clk_i) begin
    if (reset_i) begin
        if (reset_seen) begin
            checks++;
            assert (!wb_o.valid && !finish_test_o && !sel_mem_req_o && !dmem_rd_o && !dmem_wr_o)
            else begin
                errors++;
                $display("outputs not cleared during reset at %0t", $time);
            end
        end
        reset_seen = 1'b1;
        got_cnt    = 0;
        fin_cycles = 0;
    end else begin
        reset_seen = 1'b0;
        sel_exp    = (dmem_rd_o || dmem_wr_o) && !dmem_hit_i && imem_hit_i;
        fin_exp    = fin_cycles >= 3;
        checks += 3;
        assert (!(dmem_rd_o && dmem_wr_o)) else begin
            errors++;
            $display("load and store requested in the same cycle at %0t", $time);
        end
        assert (sel_mem_req_o == sel_exp) else begin
            errors++;
            $display("ERR %0t sel_mem_req_o got %b exp %b", $time, sel_mem_req_o, sel_exp);
        end
        assert (finish_test_o == fin_exp) else begin
            errors++;
            $display("ERR %0t finish_test_o got %b exp %b", $time, finish_test_o, fin_exp);
        end
        if (finish_test_i || fin_cycles > 0) begin
            fin_cycles++;  // Counts on from the first request cycle
        end
        if (wb_o.valid) begin
            checks++;
            assert (got_cnt < exp_q.size()) else begin
                errors++;
                $display("unexpected write-back to r%0d at %0t", wb_o.rd, $time);
            end
            if (got_cnt < exp_q.size()) begin
                checks += 2;
                assert (wb_o.rd == exp_q[got_cnt].rd) else begin
                    errors++;
                    $display("ERR %0t wb_o.rd got %0d exp %0d", $time, wb_o.rd,
                             exp_q[got_cnt].rd);
                end
                assert (wb_o.data == exp_q[got_cnt].data) else begin
                    errors++;
                    $display("ERR %0t wb_o.data got %h exp %h", $time, wb_o.data,
                             exp_q[got_cnt].data);
                end
            end
            got_cnt++;
        end
    end
end

//////////////////////////////////////////////////////////////////////
// Run control

task automatic run_row(input int row);
    int steps;
    int limit;
    int cycles;
    @(posedge clk_i);
    reset_i       <= 1'b1;
    finish_test_i <= 1'b0;
    for (int a = 0; a < 32; a++) begin
        imem[a] <= (a < 16) ? prog_tab[row][a] : 16'h0000;
    end
    for (int a = 0; a < 64; a++) begin
        dmem[a] <= fill_word(a);
    end
    cur_imiss = imiss_tab[row];
    cur_dmiss = dmiss_tab[row];
    cur_drain = drain_tab[row];
    run_reference(row, steps);
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    limit  = 40 + 20 * steps;  // Worst case stalls per executed instruction
    cycles = 0;
    while (got_cnt < exp_q.size() && cycles < limit) begin
        @(posedge clk_i);
        cycles++;
    end
    if (got_cnt < exp_q.size()) begin
        $display("row %0d timed out after %0d cycles with %0d of %0d write-backs",
                 row, cycles, got_cnt, exp_q.size());
        timed_out = 1'b1;
        return;
    end
    repeat (4) @(posedge clk_i);  // Room for a stray write-back
    finish_test_i <= 1'b1;
    @(posedge clk_i);
    finish_test_i <= 1'b0;  // Single cycle request
    // Anything fetched from here on would write r1
    for (int a = 0; a < 32; a++) begin
        imem[a] <= i_word(segre_pkg::OP_ADDI, 1, 1, 1);
    end
    cycles = 1;
    while (!finish_test_o && cycles < 10) begin
        @(posedge clk_i);
        cycles++;
    end
    if (!finish_test_o) begin
        $display("finish_test_o never rose in row %0d", row);
        timed_out = 1'b1;
        return;
    end
    repeat (8) @(posedge clk_i);
endtask

initial begin
    reset_i                 <= 1'b1;
    finish_test_i           <= 1'b0;
    imem_hit_i              <= 1'b1;
    dmem_hit_i              <= 1'b1;
    store_buffer_draining_i <= 1'b0;
    fill_table();
    for (int row = 0; row < num_rows && !timed_out; row++) begin
        run_row(row);
    end
    $display("checks %0d  errors %0d  timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

endmodule : tb_segre_core

// ==== vlog.f ====
+incdir+.
segre_pkg.sv
segre_if_stage.sv
segre_id_stage.sv
segre_ex_stage.sv
segre_mem_stage.sv
segre_controller.sv
segre_core.sv
tb_segre_core.sv

// ==== Makefile ====
TOP = tb_segre_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
